//--- fpu.f
+incdir+testbench
verilog/fpu_pkg.sv
verilog/fpu_except.sv
verilog/fpu_pre_norm.sv
verilog/fpu_fract_arith.sv
verilog/fpu_post_norm.sv
verilog/fpu.sv
testbench/fpu_tb.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing -Wno-fatal
TOP      := fpu_tb
FILELIST := fpu.f
OBJ_DIR  := obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/fpu_model.svh
`ifndef FPU_MODEL_SVH
`define FPU_MODEL_SVH

//////////////////////////////
// Random source
//////////////////////////////

logic [31:0] lfsr_state; // Fibonacci LFSR with taps 32 22 2 1

function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] v;
	logic fb;
	v = '0;
	for (int i = 0; i < n; i++) begin
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb}; // One step per bit
		v = {v[30:0], fb};
	end
	return v;
endfunction

//////////////////////////////
// Reference model
//////////////////////////////

// Range rules on a truncated finite value
function automatic fpu_out_t pack_finite(input logic sign, input int e, input logic [22:0] frac);
	fpu_out_t r;
	r = '0;
	if (e <= 0) begin
		r.result = {sign, 31'd0}; // Tiny result flushed
		r.flags.zero = 1'b1;
	end else if (e >= 255) begin
		r.result = {sign, MAX_FINITE}; // Round toward zero saturates
		r.flags.overflow = 1'b1;
	end else begin
		r.result = {sign, 8'(e), frac};
	end
	return r;
endfunction

function automatic fpu_out_t model_mul(input float_t a, input float_t b);
	logic [47:0] p;
	logic sign;
	int e;
	fpu_out_t r;
	sign = a[31] ^ b[31];
	r = '0;
	if (a[30:23] == 8'd0 || b[30:23] == 8'd0) begin
		r.result = {sign, 31'd0}; // Zero or denormal factor
		r.flags.zero = 1'b1;
		return r;
	end
	p = {24'd0, 1'b1, a[22:0]} * {24'd0, 1'b1, b[22:0]}; // Exact product
	e = int'(a[30:23]) + int'(b[30:23]) - EXP_BIAS;
	if (p[47]) begin
		return pack_finite(sign, e + 1, p[46:24]);
	end
	return pack_finite(sign, e, p[45:23]);
endfunction

function automatic fpu_out_t model_addsub(input float_t a, input float_t b, input logic neg_b);
	logic [30:0] mag_a, mag_b, big, lesser;
	logic sign_b, sign, rem;
	logic [63:0] bw, full, sw, x;
	int d, p;
	fpu_out_t r;
	sign_b = b[31] ^ neg_b;
	mag_a = (a[30:23] == 8'd0) ? 31'd0 : a[30:0]; // Denormal reads as zero
	mag_b = (b[30:23] == 8'd0) ? 31'd0 : b[30:0];
	big = (mag_a >= mag_b) ? mag_a : mag_b;
	lesser = (mag_a >= mag_b) ? mag_b : mag_a;
	sign = (mag_a >= mag_b) ? a[31] : sign_b; // Larger magnitude wins
	// Significands scaled far above the 24 kept bits
	bw = {6'd0, 1'b1, big[22:0], 34'd0};
	full = {6'd0, 1'b1, lesser[22:0], 34'd0};
	d = int'(big[30:23]) - int'(lesser[30:23]);
	sw = (lesser == 31'd0 || d >= 64) ? 64'd0 : full >> d;
	rem = (lesser != 31'd0) && ((sw << d) != full); // Bits below bit 0
	// A lost remainder pulls a difference down one unit before truncation
	x = (a[31] ^ sign_b) ? bw - sw - 64'(rem) : bw + sw;
	r = '0;
	if (big == 31'd0 || x == 64'd0) begin
		r.flags.zero = 1'b1; // Exact cancellation is +0
		return r;
	end
	p = 0;
	for (int i = 0; i < 64; i++) begin
		if (x[i]) begin
			p = i;
		end
	end
	x = x << (63 - p); // Leading one to bit 63
	return pack_finite(sign, int'(big[30:23]) + p - 57, x[62:40]);
endfunction

function automatic fpu_out_t model_fpu(input fpu_in_t t);
	logic a_nan, a_inf, a_zero, b_nan, b_inf, b_zero;
	logic is_mul, sign_b;
	fpu_out_t r;
	a_nan = (t.opa[30:23] == 8'hff) && (t.opa[22:0] != 23'd0);
	a_inf = (t.opa[30:23] == 8'hff) && (t.opa[22:0] == 23'd0);
	a_zero = (t.opa[30:23] == 8'd0);
	b_nan = (t.opb[30:23] == 8'hff) && (t.opb[22:0] != 23'd0);
	b_inf = (t.opb[30:23] == 8'hff) && (t.opb[22:0] == 23'd0);
	b_zero = (t.opb[30:23] == 8'd0);
	is_mul = (t.op == op_mul);
	sign_b = t.opb[31] ^ (t.op == op_sub);
	r = '0;
	if (a_nan || b_nan || (is_mul && ((a_inf && b_zero) || (b_inf && a_zero)))
			|| (!is_mul && a_inf && b_inf && (t.opa[31] != sign_b))) begin
		r.result = QNAN_VAL; // Invalid operation
		r.flags.qnan = 1'b1;
	end else if (a_inf || b_inf) begin
		r.result = {(is_mul ? (t.opa[31] ^ t.opb[31]) : (a_inf ? t.opa[31] : sign_b)), INF_VAL};
		r.flags.inf = 1'b1;
	end else if (is_mul) begin
		r = model_mul(t.opa, t.opb);
	end else begin
		r = model_addsub(t.opa, t.opb, t.op == op_sub);
	end
	return r;
endfunction

`endif

//--- testbench/fpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_tb import fpu_pkg::*; ();

	`include "fpu_model.svh"

	localparam int N_OPS = 3000;
	localparam int DRAIN_LIMIT = 4 * PIPE_LAT; // Cycles to empty the queue

	logic     fpu_if;
	logic     rst_n;
	fpu_in_t  stim;
	fpu_out_t res;
	int       cycle;   // Falling edges since reset release
	int       checks;
	int       errors;
	int       wait_cnt;

	fpu_in_t  in_q[$];    // Applied operations
	fpu_out_t exp_q[$];   // Model results
	int       stamp_q[$]; // Edge each op was applied
	string    name_q[$];

	fpu uut (
		.fpu_if (fpu_if),
		.rst_n  (rst_n),
		.in     (stim),
		.out    (res)
	);

	always #50 fpu_if = ~fpu_if; // 100 ns period

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	// Biased mix, exponents 0 and 255 show up often
	function automatic float_t rand_operand();
		logic [4:0] kind;
		logic [7:0] e;
		logic [22:0] f;
		logic s;
		kind = 5'(rand_bits(5));
		s = 1'(rand_bits(1));
		e = 8'(rand_bits(8));
		f = 23'(rand_bits(23));
		case (kind)
			5'd0: e = 8'd0; // Denormal
			5'd1: begin
				e = 8'd0;
				f = 23'd0;
			end
			5'd2: e = 8'd255; // NaN unless f is zero
			5'd3: begin
				e = 8'd255;
				f = 23'd0;
			end
			5'd4: e = 8'd253 + 8'(rand_bits(1)); // Near overflow
			5'd5: e = 8'd1 + 8'(rand_bits(1));   // Near flush
			default: begin
				if (e == 8'd0) e = 8'd1;
				else if (e == 8'd255) e = 8'd254;
			end
		endcase
		return {s, e, f};
	endfunction

	function automatic string test_name(input fpu_in_t t, input fpu_out_t e);
		if (e.flags.inf || e.flags.qnan) return "special";
		if (t.opa[30:23] == 8'd0 || t.opb[30:23] == 8'd0) return "denormal";
		return t.op.name();
	endfunction

	task automatic apply_next();
		fpu_in_t t;
		logic [2:0] mode;
		logic [1:0] o;
		t.opa = rand_operand();
		mode = 3'(rand_bits(3));
		if (mode == 3'd0) begin
			t.opb = {1'(rand_bits(1)), t.opa[30:0]}; // Same magnitude
		end else if (mode <= 3'd2) begin
			t.opb = {1'(rand_bits(1)), t.opa[30:23], 23'(rand_bits(23))}; // Equal exponent
		end else begin
			t.opb = rand_operand();
		end
		o = 2'(rand_bits(2));
		t.op = (o == 2'd3) ? op_sub : fpu_op_t'(o);
		stim = t;
		in_q.push_back(t);
		exp_q.push_back(model_fpu(t));
		stamp_q.push_back(cycle);
		name_q.push_back(test_name(t, exp_q[$]));
	endtask

	//////////////////////////////
	// Checks
	//////////////////////////////

	task automatic check_zero(input string name);
		checks++;
		if (res !== '0) begin
			errors++;
			$display("FAILED %s: expected %h, actual %h", name, 36'h0, res);
		end
	endtask

	// Driven half a cycle before edge k, visible one falling edge after edge k+PIPE_LAT
	task automatic check_due();
		if (stamp_q.size() != 0 && stamp_q[0] + PIPE_LAT + 1 == cycle) begin
			checks++;
			if (res !== exp_q[0]) begin
				errors++;
				$display("FAILED %s: opa=%h opb=%h expected %h/%b, actual %h/%b",
					name_q[0], in_q[0].opa, in_q[0].opb,
					exp_q[0].result, exp_q[0].flags, res.result, res.flags);
			end
			void'(in_q.pop_front());
			void'(exp_q.pop_front());
			void'(stamp_q.pop_front());
			void'(name_q.pop_front());
		end
	endtask

	initial fpu_if = 1'b0;

	initial begin
		rst_n = 1'b0;
		stim = '0;
		lfsr_state = 32'd81794;
		cycle = 0;
		checks = 0;
		errors = 0;
		wait_cnt = 0;
		for (int i = 0; i < 2; i++) begin // Two cycles in reset
			@(negedge fpu_if);
			check_zero("reset");
		end
		rst_n = 1'b1;
		#1;
		check_zero("reset_release");
		for (int n = 0; n < N_OPS; n++) begin
			@(negedge fpu_if);
			cycle++;
			check_due(); // Sample before the new drive
			apply_next();
		end
		while (stamp_q.size() != 0 && wait_cnt < DRAIN_LIMIT) begin
			@(negedge fpu_if);
			cycle++;
			check_due();
			wait_cnt++;
		end
		if (stamp_q.size() != 0) begin
			errors++;
			$display("Timeout: %0d results never came out of the pipeline", stamp_q.size());
		end
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/fpu.sv
`timescale 1ns/1ps
`default_nettype none

module fpu import fpu_pkg::*; (
	input  logic     fpu_if,
	input  logic     rst_n,
	input  fpu_in_t  in,
	output fpu_out_t out
);

	fpu_in_t   in_r;        // Stage 1
	special_t  special;     // Stage 2
	special_t  special_d1;  // Stage 3
	special_t  special_d2;  // Stage 4
	pre_norm_t pre;         // Stage 2
	arith_t    arith;       // Stage 3
	arith_t    arith_r;     // Stage 4
	fpu_out_t  finite;      // Post-normalized word
	fpu_out_t  out_d;

	//////////////////////////////
	// Stage 1 input register
	//////////////////////////////

	always_ff @(posedge fpu_if or negedge rst_n) begin
		if (!rst_n) begin
			in_r <= '0;
		end else begin
			in_r <= in;
		end
	end

	fpu_except u_except (
		.fpu_if  (fpu_if),
		.rst_n   (rst_n),
		.in      (in_r),
		.special (special)
	);

	fpu_pre_norm u_pre_norm (
		.fpu_if (fpu_if),
		.rst_n  (rst_n),
		.in     (in_r),
		.pre    (pre)
	);

	fpu_fract_arith u_fract_arith (
		.fpu_if (fpu_if),
		.rst_n  (rst_n),
		.pre    (pre),
		.arith  (arith)
	);

	//////////////////////////////
	// Stage 4 alignment
	//////////////////////////////

	// Product gets a full cycle before normalization, special rides along
	always_ff @(posedge fpu_if or negedge rst_n) begin
		if (!rst_n) begin
			arith_r <= '0;
			special_d1 <= '0;
			special_d2 <= '0;
		end else begin
			arith_r <= arith;
			special_d1 <= special;
			special_d2 <= special_d1;
		end
	end

	fpu_post_norm u_post_norm (
		.fract  (arith_r.fract),
		.exp    (arith_r.exp),
		.sign   (arith_r.sign),
		.is_mul (arith_r.is_mul),
		.result (finite)
	);

	//////////////////////////////
	// Output select and register
	//////////////////////////////

	always_comb begin
		out_d = finite;
		if (special_d2.forced) begin
			out_d = '0;
			if (special_d2.is_nan) begin
				out_d.result = QNAN_VAL;
				out_d.flags.qnan = 1'b1;
			end else begin
				out_d.result = {special_d2.sign, INF_VAL}; // Signed infinity
				out_d.flags.inf = 1'b1;
			end
		end
	end

	always_ff @(posedge fpu_if or negedge rst_n) begin
		if (!rst_n) begin
			out <= '0; // Reads +0, flags low
		end else begin
			out <= out_d;
		end
	end

endmodule

`default_nettype wire

//--- verilog/fpu_post_norm.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_post_norm import fpu_pkg::*; (
	input  prod_t    fract,
	input  ext_exp_t exp,
	input  logic     sign,
	input  logic     is_mul,
	output fpu_out_t result
);

	// Leading zeros of the raw fraction, MSB first
	function automatic logic [5:0] lead_zeros(input prod_t f);
		logic [5:0] n;
		logic found;
		n = '0;
		found = 1'b0;
		for (int i = 47; i >= 0; i--) begin
			if (!found && f[i]) begin
				n = 6'(47 - i);
				found = 1'b1;
			end
		end
		return n;
	endfunction

	logic [5:0] lz;
	prod_t      norm;       // Leading one at bit 47
	ext_exp_t   exp_norm;
	logic       fract_zero;
	logic       zero_sign;

	//////////////////////////////
	// Normalize
	//////////////////////////////

	assign lz = lead_zeros(fract);
	assign norm = fract << lz;

	// Hidden bit sits at 46, so a one at 47 bumps the exponent
	assign exp_norm = exp + 10'sd1 - $signed({4'b0000, lz});

	assign fract_zero = (fract == '0);
	assign zero_sign = is_mul & sign; // Add/sub cancellation is +0

	//////////////////////////////
	// Range checks and pack
	//////////////////////////////

	always_comb begin
		result = '0;
		if (fract_zero) begin
			result.result = {zero_sign, 31'd0};
			result.flags.zero = 1'b1;
		end else if (exp_norm <= 0) begin
			// Tiny result, flush
			result.result = {sign, 31'd0};
			result.flags.zero = 1'b1;
		end else if (exp_norm >= EXP_INF) begin
			// Round toward zero saturates at the largest normal
			result.result = {sign, MAX_FINITE};
			result.flags.overflow = 1'b1;
		end else begin
			result.result = {sign, exp_norm[7:0], norm[46:24]}; // Truncate the rest
		end
	end

endmodule

`default_nettype wire

//--- verilog/fpu_fract_arith.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_fract_arith import fpu_pkg::*; (
	input  logic      fpu_if,
	input  logic      rst_n,
	input  pre_norm_t pre,
	output arith_t    arith
);

	logic [FRACT_W:0] sum;     // Carry out in the top bit
	prod_t            product; // 24x24 significand product

	//////////////////////////////
	// Fraction add/sub
	//////////////////////////////

	// fracta is never smaller than fractb, so no negative difference
	always_comb begin
		if (pre.sub) begin
			sum = {1'b0, pre.fracta} - {1'b0, pre.fractb};
		end else begin
			sum = {1'b0, pre.fracta} + {1'b0, pre.fractb};
		end
	end

	//////////////////////////////
	// Fraction multiply
	//////////////////////////////

	assign product = pre.mant_a * pre.mant_b; // Hidden bit lands on bit 46

	//////////////////////////////
	// Stage 3 register
	//////////////////////////////

	always_ff @(posedge fpu_if or negedge rst_n) begin
		if (!rst_n) begin
			arith <= '0;
		end else begin
			// Sum goes to the top so both paths share one hidden-bit position
			if (pre.is_mul) begin
				arith.fract <= product;
			end else begin
				arith.fract <= {sum, 20'd0};
			end
			arith.exp <= pre.exp;
			arith.sign <= pre.sign;
			arith.is_mul <= pre.is_mul;
		end
	end

endmodule

`default_nettype wire

//--- verilog/fpu_pre_norm.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_pre_norm import fpu_pkg::*; (
	input  logic      fpu_if,
	input  logic      rst_n,
	input  fpu_in_t   in,
	output pre_norm_t pre
);

	exp_t     exp_a, exp_b;
	mant_t    mant_a, mant_b;
	logic     is_mul;
	logic     sign_b;       // opb sign after op_sub negation
	logic     a_big;        // |opa| >= |opb|
	exp_t     exp_big;
	exp_t     exp_diff;     // Alignment shift
	mant_t    mant_big;
	mant_t    mant_small;
	fract_t   small_ext;
	fract_t   small_sh;
	fract_t   lost_mask;
	logic     sticky;
	ext_exp_t exp_mul;

	//////////////////////////////
	// Unpack
	//////////////////////////////

	assign exp_a = in.opa[30:23];
	assign exp_b = in.opb[30:23];

	// Exponent zero reads as a zero significand
	assign mant_a = (exp_a == '0) ? '0 : {1'b1, in.opa[22:0]};
	assign mant_b = (exp_b == '0) ? '0 : {1'b1, in.opb[22:0]};

	assign is_mul = (in.op == op_mul);
	assign sign_b = in.opb[31] ^ (in.op == op_sub);

	//////////////////////////////
	// Add/sub alignment
	//////////////////////////////

	// Magnitude compare on exponent then significand
	assign a_big = {exp_a, mant_a} >= {exp_b, mant_b};

	assign exp_big = a_big ? exp_a : exp_b;
	assign exp_diff = a_big ? (exp_a - exp_b) : (exp_b - exp_a);
	assign mant_big = a_big ? mant_a : mant_b;
	assign mant_small = a_big ? mant_b : mant_a;

	assign small_ext = {mant_small, 3'b000}; // Append G, R, S
	assign small_sh = small_ext >> exp_diff; // Large shifts give zero

	// Bits pushed out the bottom
	assign lost_mask = ~({FRACT_W{1'b1}} << exp_diff);
	assign sticky = |(small_ext & lost_mask);

	//////////////////////////////
	// Multiply exponent
	//////////////////////////////

	// Sum of biased exponents, rebiased once
	assign exp_mul = $signed({2'b00, exp_a}) + $signed({2'b00, exp_b})
		- ext_exp_t'(EXP_BIAS);

	//////////////////////////////
	// Stage 2 register
	//////////////////////////////

	always_ff @(posedge fpu_if or negedge rst_n) begin
		if (!rst_n) begin
			pre <= '0;
		end else begin
			pre.fracta <= {mant_big, 3'b000};
			pre.fractb <= {small_sh[FRACT_W-1:1], small_sh[0] | sticky}; // Sticky in LSB
			pre.mant_a <= mant_a;
			pre.mant_b <= mant_b;
			pre.exp <= is_mul ? exp_mul : $signed({2'b00, exp_big});
			// Result sign follows the larger magnitude
			pre.sign <= is_mul ? (in.opa[31] ^ in.opb[31]) :
				(a_big ? in.opa[31] : sign_b);
			pre.sub <= !is_mul & (in.opa[31] ^ sign_b);
			pre.is_mul <= is_mul;
		end
	end

endmodule

`default_nettype wire

//--- verilog/fpu_except.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_except import fpu_pkg::*; (
	input  logic     fpu_if,
	input  logic     rst_n,
	input  fpu_in_t  in,
	output special_t special
);

	// Returns {nan, inf, zero}, denormals count as zero
	function automatic logic [2:0] classify(input float_t f);
		exp_t e;
		logic frac_nz;
		e = f[30:23];
		frac_nz = |f[22:0];
		return {(e == exp_t'(EXP_INF)) & frac_nz, (e == exp_t'(EXP_INF)) & !frac_nz, e == '0};
	endfunction

	logic a_nan, a_inf, a_zero;
	logic b_nan, b_inf, b_zero;
	logic is_mul;
	logic sign_b;   // opb sign as seen by the adder
	logic eff_sub;
	logic nan_d;
	logic inf_d;
	logic sign_d;

	//////////////////////////////
	// Operand classes
	//////////////////////////////

	assign {a_nan, a_inf, a_zero} = classify(in.opa);
	assign {b_nan, b_inf, b_zero} = classify(in.opb);

	assign is_mul = (in.op == op_mul);
	assign sign_b = in.opb[31] ^ (in.op == op_sub);
	assign eff_sub = in.opa[31] ^ sign_b;

	// Invalid cases go to QNAN
	assign nan_d = a_nan | b_nan
		| (!is_mul & a_inf & b_inf & eff_sub)           // inf - inf
		| (is_mul & ((a_inf & b_zero) | (b_inf & a_zero))); // 0 * inf

	assign inf_d = a_inf | b_inf; // NaN takes priority in the top mux

	// Sign of the forced infinity
	assign sign_d = is_mul ? (in.opa[31] ^ in.opb[31]) :
		a_inf ? in.opa[31] : sign_b;

	//////////////////////////////
	// Stage 2 register
	//////////////////////////////

	always_ff @(posedge fpu_if or negedge rst_n) begin
		if (!rst_n) begin
			special <= '0;
		end else begin
			special.forced <= nan_d | inf_d;
			special.is_nan <= nan_d;
			special.sign <= sign_d;
		end
	end

endmodule

`default_nettype wire

//--- verilog/fpu_pkg.sv
`default_nettype none

package fpu_pkg;

	//////////////////////////////
	// Widths and constants
	//////////////////////////////

	localparam int EXP_BIAS = 127;
	localparam int EXP_INF = 255;                     // All-ones exponent
	localparam int FRACT_W = 27;                      // Hidden bit, 23 fraction bits, G R S
	localparam logic [31:0] QNAN_VAL = 32'h7fc00001;   // Quiet NaN word
	localparam logic [30:0] INF_VAL = 31'h7f800000;    // Magnitude only
	localparam logic [30:0] MAX_FINITE = 31'h7f7fffff; // Largest normal magnitude
	localparam int PIPE_LAT = 4;                      // Input sample to output register

	//////////////////////////////
	// Scalar types
	//////////////////////////////

	typedef logic [31:0] float_t;          // IEEE single
	typedef logic [7:0] exp_t;             // Biased exponent
	typedef logic signed [9:0] ext_exp_t;  // Room for overflow and underflow
	typedef logic [23:0] mant_t;           // Significand with hidden bit
	typedef logic [FRACT_W-1:0] fract_t;   // Aligned add/sub fraction
	typedef logic [47:0] prod_t;           // Raw sum or product

	// Supported operations
	typedef enum logic [1:0] {
		op_add = 2'b00,
		op_sub = 2'b01,
		op_mul = 2'b10
	} fpu_op_t;

	//////////////////////////////
	// Pipeline bundles
	//////////////////////////////

	typedef struct packed {
		float_t  opa;
		float_t  opb;
		fpu_op_t op;
	} fpu_in_t;

	typedef struct packed {
		logic inf;
		logic qnan;
		logic zero;
		logic overflow;
	} fpu_flags_t;

	typedef struct packed {
		float_t     result;
		fpu_flags_t flags;
	} fpu_out_t;

	// Forced special result, decided in stage 2
	typedef struct packed {
		logic forced;  // Override the computed word
		logic is_nan;  // QNAN when set, else signed INF
		logic sign;
	} special_t;

	typedef struct packed {
		fract_t   fracta;  // Larger operand
		fract_t   fractb;  // Smaller operand, aligned with sticky
		mant_t    mant_a;  // Raw significands for multiply
		mant_t    mant_b;
		ext_exp_t exp;
		logic     sign;
		logic     sub;     // Effective subtract
		logic     is_mul;
	} pre_norm_t;

	typedef struct packed {
		prod_t    fract;
		ext_exp_t exp;
		logic     sign;
		logic     is_mul;
	} arith_t;

endpackage

`default_nettype wire
